// ==== Makefile ====
# Verilator flow for the host I/O link testbench

VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_hps_link
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the log search decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/file_loader.sv ====
/*
 * file download control
 * index, extension, download framing and the byte write strobe
 */
`timescale 1ns/100ps

module file_loader import hps_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      cmd_stb,
	input  logic      data_stb,
	input  file_op_t  fop,
	input  word_idx_t word_idx,
	input  word_t     io_din,
	input  addr_t     addr,
	output logic      ioctl_download,
	output logic      ioctl_wr,
	output word_t     ioctl_index,
	output logic [31:0] ioctl_file_ext,
	output addr_t     ioctl_addr,
	output logic [7:0] ioctl_dout,
	output logic      addr_clear,
	output logic      addr_load_lo,
	output logic      addr_load_hi,
	output logic      addr_step,
	output word_t     load_word
);

	logic tx_word;
	logic tx_end;

	// only data words of FILE_TX move the download state
	assign tx_word = data_stb && (fop == FOP_FILE_TX);
	assign tx_end  = tx_word && (word_idx == 4'd1) && (io_din[7:0] == 8'h00);

	//////////////////////////////////////////////////////////////
	// counter controls
	//////////////////////////////////////////////////////////////
	assign addr_clear   = tx_word && (word_idx == 4'd1) && (io_din[7:0] != 8'h00);
	assign addr_load_lo = tx_word && (word_idx == 4'd2);
	assign addr_load_hi = tx_word && (word_idx == 4'd3);
	assign addr_step    = data_stb && (fop == FOP_FILE_TX_DAT) && ioctl_download;
	assign load_word    = io_din;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
		end else begin
			// one pulse per accepted data word
			ioctl_wr <= addr_step;
			if (addr_step) begin
				ioctl_addr <= addr;
				ioctl_dout <= io_din[7:0];
			end

			if (addr_clear) ioctl_download <= 1'b1;
			if (tx_end) begin
				// leave the end address visible as the loaded length
				if (ioctl_download) ioctl_addr <= addr;
				ioctl_download <= 1'b0;
			end

			if (data_stb && !cmd_stb) begin
				case (fop)
					FOP_FILE_INDEX: ioctl_index <= io_din;
					FOP_FILE_INFO: begin
						if (word_idx == 4'd1) ioctl_file_ext[31:16] <= io_din;
						if (word_idx == 4'd2) ioctl_file_ext[15:0]  <= io_din;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== design/host_cmd_fsm.sv ====
/*
 * host command framer
 * splits each enable frame into a command word and data words, decodes the opcode
 */
`timescale 1ns/100ps

module host_cmd_fsm import hps_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      io_strobe,
	input  logic      io_enable,
	input  logic      fp_enable,
	input  word_t     io_din,
	output logic      cmd_stb,
	output logic      data_stb,
	output host_op_t  op,
	output file_op_t  fop,
	output word_idx_t word_idx
);

	link_state_t state;
	link_state_t state_nx;
	host_op_t    op_q;
	host_op_t    op_dec;
	file_op_t    fop_q;
	file_op_t    fop_dec;
	word_idx_t   idx_q;

	// first strobe of a frame is the command word
	assign cmd_stb  = io_strobe && (state == ST_IDLE) && (io_enable || fp_enable);
	assign data_stb = io_strobe &&
		(((state == ST_CMD_CH) && io_enable) || ((state == ST_FILE_CH) && fp_enable));

	//////////////////////////////////////////////////////////////
	// opcode decode for the enabled channel only
	//////////////////////////////////////////////////////////////
	always_comb begin
		op_dec  = OP_NONE;
		fop_dec = FOP_NONE;
		if (io_enable) begin
			case (io_din)
				OP_CFG, OP_JOY0, OP_JOY1, OP_STATUS, OP_STATUS_GET: op_dec = host_op_t'(io_din);
				default: op_dec = OP_NONE;
			endcase
		end
		if (fp_enable) begin
			case (io_din)
				FOP_FILE_TX, FOP_FILE_TX_DAT, FOP_FILE_INDEX, FOP_FILE_INFO:
					fop_dec = file_op_t'(io_din);
				default: fop_dec = FOP_NONE;
			endcase
		end
	end

	// live decode in the command cycle and the latched value after it
	assign op       = cmd_stb ? op_dec : op_q;
	assign fop      = cmd_stb ? fop_dec : fop_q;
	assign word_idx = idx_q;

	always_comb begin
		state_nx = state;
		case (state)
			ST_IDLE:    if (cmd_stb) state_nx = io_enable ? ST_CMD_CH : ST_FILE_CH;
			ST_CMD_CH:  if (!io_enable) state_nx = ST_IDLE;
			ST_FILE_CH: if (!fp_enable) state_nx = ST_IDLE;
			default:    state_nx = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			op_q  <= OP_NONE;
			fop_q <= FOP_NONE;
			idx_q <= '0;
		end else begin
			state <= state_nx;
			if (state_nx == ST_IDLE) begin
				op_q  <= OP_NONE;
				fop_q <= FOP_NONE;
				idx_q <= '0;
			end else if (cmd_stb) begin
				op_q  <= op_dec;
				fop_q <= fop_dec;
				idx_q <= 4'd1;
			end else if (data_stb && (idx_q != 4'hF)) begin
				// saturate so long commands keep a stable index
				idx_q <= idx_q + 4'd1;
			end
		end
	end

endmodule

// ==== design/host_regs.sv ====
/*
 * host register file
 * config, joystick and status words plus status request capture and read-back
 */
`timescale 1ns/100ps

module host_regs import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                cmd_stb,
	input  logic                data_stb,
	input  logic                io_enable,
	input  logic                status_set,
	input  host_op_t            op,
	input  word_idx_t           word_idx,
	input  word_t               io_din,
	input  logic [STATUS_W-1:0] status_in,
	output word_t               io_dout,
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic                direct_video,
	output logic [JOY_W-1:0]    joystick_0,
	output logic [JOY_W-1:0]    joystick_1,
	output logic [STATUS_W-1:0] status
);

	word_t               cfg;
	logic                status_set_q;
	logic [3:0]          stflg;
	logic [STATUS_W-1:0] status_req;
	logic [2:0]          slice_sel;
	logic                slice_ok;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[CFG_SD_BIT];
	assign direct_video       = cfg[CFG_DV_BIT];

	// data words 1..8 map onto status slices 0..7
	assign slice_sel = 3'(word_idx - 4'd1);
	assign slice_ok  = (word_idx != 4'd0) && (word_idx <= word_idx_t'(STATUS_WORDS));

	// word 1 is the low half and anything after it the high half
	function automatic logic [JOY_W-1:0] joy_write(
		input logic [JOY_W-1:0] cur,
		input word_idx_t        idx,
		input word_t            din
	);
		logic [JOY_W-1:0] nxt;
		nxt = cur;
		if (idx == 4'd1)
			nxt[JOY_W/2-1:0] = din;
		else
			nxt[JOY_W-1:JOY_W/2] = din;
		return nxt;
	endfunction

	//////////////////////////////////////////////////////////////
	// register writes and read-back
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg          <= '0;
			joystick_0   <= '0;
			joystick_1   <= '0;
			status       <= '0;
			status_set_q <= 1'b0;
			stflg        <= '0;
			status_req   <= '0;
			io_dout      <= '0;
		end else begin
			// core asks for a status change on the rising edge
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				stflg      <= stflg + 4'd1;
				status_req <= status_in;
			end

			if (!io_enable) begin
				io_dout <= '0;
			end else if (cmd_stb) begin
				io_dout <= (op == OP_STATUS_GET) ? {8'h00, STFLG_TAG, stflg} : '0;
			end else if (data_stb) begin
				io_dout <= '0;
				case (op)
					OP_CFG:  cfg <= io_din;
					OP_JOY0: joystick_0 <= joy_write(joystick_0, word_idx, io_din);
					OP_JOY1: joystick_1 <= joy_write(joystick_1, word_idx, io_din);
					OP_STATUS: begin
						if (slice_ok)
							status[{slice_sel, 4'b0000} +: 16] <= io_din;
					end
					OP_STATUS_GET: begin
						if (slice_ok)
							io_dout <= status_req[{slice_sel, 4'b0000} +: 16];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== design/hps_link_top.sv ====
/*
 * host I/O link top
 * framer, host registers, file loader and download address counter
 */
`timescale 1ns/100ps

module hps_link_top import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                io_strobe,
	input  logic                io_enable,
	input  logic                fp_enable,
	input  word_t               io_din,
	output word_t               io_dout,
	input  logic [STATUS_W-1:0] status_in,
	input  logic                status_set,
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic                direct_video,
	output logic [JOY_W-1:0]    joystick_0,
	output logic [JOY_W-1:0]    joystick_1,
	output logic [STATUS_W-1:0] status,
	output logic                ioctl_download,
	output word_t               ioctl_index,
	output logic [31:0]         ioctl_file_ext,
	output logic                ioctl_wr,
	output addr_t               ioctl_addr,
	output logic [7:0]          ioctl_dout
);

	logic      cmd_stb;
	logic      data_stb;
	host_op_t  op;
	file_op_t  fop;
	word_idx_t word_idx;
	logic      addr_clear;
	logic      addr_load_lo;
	logic      addr_load_hi;
	logic      addr_step;
	word_t     load_word;
	addr_t     addr;

	host_cmd_fsm u_fsm (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_din    (io_din),
		.cmd_stb   (cmd_stb),
		.data_stb  (data_stb),
		.op        (op),
		.fop       (fop),
		.word_idx  (word_idx)
	);

	host_regs u_regs (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.cmd_stb            (cmd_stb),
		.data_stb           (data_stb),
		.io_enable          (io_enable),
		.status_set         (status_set),
		.op                 (op),
		.word_idx           (word_idx),
		.io_din             (io_din),
		.status_in          (status_in),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	file_loader u_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.cmd_stb        (cmd_stb),
		.data_stb       (data_stb),
		.fop            (fop),
		.word_idx       (word_idx),
		.io_din         (io_din),
		.addr           (addr),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.addr_clear     (addr_clear),
		.addr_load_lo   (addr_load_lo),
		.addr_load_hi   (addr_load_hi),
		.addr_step      (addr_step),
		.load_word      (load_word)
	);

	load_addr_counter u_addr (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.addr_clear   (addr_clear),
		.addr_load_lo (addr_load_lo),
		.addr_load_hi (addr_load_hi),
		.addr_step    (addr_step),
		.load_word    (load_word),
		.addr         (addr)
	);

endmodule

// ==== design/hps_pkg.sv ====
/*
 * host link package
 * bus word types, opcode and state enums, widths and fixed field constants
 */
package hps_pkg;

	//////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////
	localparam int WORD_W       = 16;
	localparam int IDX_W        = 4;
	localparam int ADDR_W       = 27;
	// the upper address word only carries the bits above the low 16
	localparam int ADDR_HI_W    = ADDR_W - WORD_W;
	localparam int STATUS_WORDS = 8;
	localparam int STATUS_W     = STATUS_WORDS * WORD_W;
	localparam int JOY_W        = 32;

	//////////////////////////////////////////////////////////////
	// fixed fields
	//////////////////////////////////////////////////////////////
	// config word bit positions
	localparam int CFG_SD_BIT = 4;
	localparam int CFG_DV_BIT = 10;

	// upper nibble of the status request reply
	localparam logic [3:0] STFLG_TAG = 4'hA;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [IDX_W-1:0]  word_idx_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// command channel opcodes
	typedef enum logic [WORD_W-1:0] {
		OP_NONE       = 16'h0000,
		OP_CFG        = 16'h0001,
		OP_JOY0       = 16'h0002,
		OP_JOY1       = 16'h0003,
		OP_STATUS     = 16'h001E,
		OP_STATUS_GET = 16'h0029
	} host_op_t;

	// file channel opcodes
	typedef enum logic [WORD_W-1:0] {
		FOP_NONE        = 16'h0000,
		FOP_FILE_TX     = 16'h0053,
		FOP_FILE_TX_DAT = 16'h0054,
		FOP_FILE_INDEX  = 16'h0055,
		FOP_FILE_INFO   = 16'h0056
	} file_op_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CMD_CH,
		ST_FILE_CH
	} link_state_t;

endpackage

// ==== design/load_addr_counter.sv ====
/*
 * download address counter
 * clear, half-word loads and single steps, in that priority
 */
`timescale 1ns/100ps

module load_addr_counter import hps_pkg::*; (
	input  logic  clk_sys,
	input  logic  arst_n,
	input  logic  addr_clear,
	input  logic  addr_load_lo,
	input  logic  addr_load_hi,
	input  logic  addr_step,
	input  word_t load_word,
	output addr_t addr
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			addr <= '0;
		end else if (addr_clear) begin
			addr <= '0;
		end else if (addr_load_lo) begin
			addr[WORD_W-1:0] <= load_word;
		end else if (addr_load_hi) begin
			// only the low bits of the upper word are meaningful
			addr[ADDR_W-1:WORD_W] <= load_word[ADDR_HI_W-1:0];
		end else if (addr_step) begin
			// wraps at the top of the address space
			addr <= addr + addr_t'(1);
		end
	end

endmodule

// ==== tb.f ====
design/hps_pkg.sv
design/host_cmd_fsm.sv
design/host_regs.sv
design/file_loader.sv
design/load_addr_counter.sv
design/hps_link_top.sv
tb/tb_hps_link.sv

// ==== tb/tb_hps_link.sv ====
/*
 * host link testbench
 * directed tests for the config, joystick, status and file download paths
 */
`timescale 1ns/100ps

module tb_hps_link import hps_pkg::*;;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_STATUS_SET = 18;
	localparam int N_BYTES      = 12;
	// strobes per test with each status_set pulse counted as one
	localparam int TOTAL_STROBES = 2 + 9 + 10 + (9 + N_STATUS_SET) + (14 + N_BYTES);
	localparam int WATCHDOG_NS   = (TOTAL_STROBES * 10 + RESET_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hcd1bf668;

	logic                clk_sys = 1'b0;
	logic                arst_n;
	logic                io_strobe;
	logic                io_enable;
	logic                fp_enable;
	word_t               io_din;
	word_t               io_dout;
	logic [STATUS_W-1:0] status_in;
	logic                status_set;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [STATUS_W-1:0] status;
	logic                ioctl_download;
	word_t               ioctl_index;
	logic [31:0]         ioctl_file_ext;
	logic                ioctl_wr;
	addr_t               ioctl_addr;
	logic [7:0]          ioctl_dout;

	int                  errors = 0;
	int                  tests_passed = 0;
	int                  tests_failed = 0;
	int                  wr_count = 0;
	logic                wr_prev = 1'b0;
	addr_t               exp_wr_addr[$];
	logic [7:0]          exp_wr_data[$];
	word_t               cfg_exp;
	logic [JOY_W-1:0]    joy0_exp;
	logic [JOY_W-1:0]    joy1_exp;
	logic [STATUS_W-1:0] status_exp;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	hps_link_top u_dut (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.status_in          (status_in),
		.status_set         (status_set),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_joy(input string what, input logic [JOY_W-1:0] exp,
			input logic [JOY_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_status(input string what, input logic [STATUS_W-1:0] exp,
			input logic [STATUS_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_addr(input string what, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - err_before);
		end
	endtask

	// config fields at buttons 1:0, scandoubler 4 and direct video 10
	function automatic word_t cfg_view(input word_t w);
		return {5'd0, w[10], 5'd0, w[4], 2'd0, w[1:0]};
	endfunction

	function automatic logic [STATUS_W-1:0] rand_status();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	////////////////////////////////////////////////////////////
	// host bus driver
	////////////////////////////////////////////////////////////
	// one strobe, returns in the middle of the cycle after it
	task automatic send_word(input word_t w);
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= w;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic send_cmd(input logic file_ch, input word_t w);
		@(posedge clk_sys);
		io_enable <= !file_ch;
		fp_enable <= file_ch;
		send_word(w);
	endtask

	task automatic end_frame();
		@(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// every write pulse must match the next expected byte
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			wr_count++;
			if (wr_prev) begin
				errors++;
				$display("ioctl_wr stayed high for more than one clock at %0t", $time);
			end
			if (exp_wr_addr.size() == 0) begin
				errors++;
				$display("unexpected write pulse at %0t", $time);
			end else begin
				check_addr("ioctl_addr", exp_wr_addr.pop_front(), ioctl_addr);
				check_word("ioctl_dout", {8'h00, exp_wr_data.pop_front()}, {8'h00, ioctl_dout});
			end
		end
		wr_prev = ioctl_wr;
	end

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic test_config();
		int    err0;
		word_t w;
		err0 = errors;
		check_word("io_dout after reset", '0, io_dout);
		check_word("write and download after reset", '0, {14'd0, ioctl_wr, ioctl_download});
		w = 16'($urandom);
		send_cmd(1'b0, OP_CFG);
		check_word("io_dout after cfg command", '0, io_dout);
		send_word(w);
		check_word("io_dout after cfg data", '0, io_dout);
		cfg_exp = w;
		check_word("config fields", cfg_view(cfg_exp),
			{5'd0, direct_video, 5'd0, forced_scandoubler, 2'd0, buttons});
		end_frame();
		report_test("config", err0);
	endtask

	task automatic test_joysticks();
		int    err0;
		word_t lo;
		word_t hi;
		err0 = errors;
		lo = 16'($urandom);
		hi = 16'($urandom);
		send_cmd(1'b0, OP_JOY0);
		send_word(lo);
		send_word(hi);
		end_frame();
		joy0_exp = {hi, lo};
		lo = 16'($urandom);
		hi = 16'($urandom);
		send_cmd(1'b0, OP_JOY1);
		send_word(lo);
		send_word(hi);
		end_frame();
		joy1_exp = {hi, lo};
		check_joy("joystick_0", joy0_exp, joystick_0);
		check_joy("joystick_1", joy1_exp, joystick_1);
		// unknown opcode with data must not touch any register
		send_cmd(1'b0, 16'h00FF);
		send_word(16'($urandom));
		send_word(16'($urandom));
		end_frame();
		check_joy("joystick_0 after unknown opcode", joy0_exp, joystick_0);
		check_joy("joystick_1 after unknown opcode", joy1_exp, joystick_1);
		check_word("config after unknown opcode", cfg_view(cfg_exp),
			{5'd0, direct_video, 5'd0, forced_scandoubler, 2'd0, buttons});
		check_status("status after unknown opcode", status_exp, status);
		report_test("joysticks", err0);
	endtask

	task automatic test_status_write();
		int    err0;
		int    i;
		word_t w;
		err0 = errors;
		send_cmd(1'b0, OP_STATUS);
		for (i = 0; i < 8; i++) begin
			w = 16'($urandom);
			status_exp[i*16 +: 16] = w;
			send_word(w);
		end
		// ninth word falls outside the vector
		send_word(16'($urandom));
		end_frame();
		check_status("status", status_exp, status);
		report_test("status write", err0);
	endtask

	task automatic test_status_request();
		int                  err0;
		int                  i;
		logic [STATUS_W-1:0] val;
		logic [STATUS_W-1:0] captured;
		err0 = errors;
		captured = '0;
		for (i = 0; i < N_STATUS_SET; i++) begin
			val = rand_status();
			@(posedge clk_sys);
			status_in  <= val;
			status_set <= 1'b1;
			@(posedge clk_sys);
			status_set <= 1'b0;
			captured = val;
		end
		// the reply must keep the capture while the live input moves on
		@(posedge clk_sys);
		status_in <= rand_status();
		send_cmd(1'b0, OP_STATUS_GET);
		check_word("status request reply", {8'h00, STFLG_TAG, 4'(N_STATUS_SET % 16)}, io_dout);
		for (i = 0; i < 8; i++) begin
			send_word(16'($urandom));
			check_word("status request slice", captured[i*16 +: 16], io_dout);
		end
		end_frame();
		check_word("io_dout with enable low", '0, io_dout);
		report_test("status request", err0);
	endtask

	task automatic test_download();
		int         err0;
		int         i;
		word_t      idx;
		word_t      ext_hi;
		word_t      ext_lo;
		word_t      start_lo;
		word_t      start_hi;
		addr_t      start;
		logic [7:0] b;
		err0 = errors;
		idx = 16'($urandom);
		send_cmd(1'b1, FOP_FILE_INDEX);
		send_word(idx);
		end_frame();
		check_word("ioctl_index", idx, ioctl_index);
		ext_hi = 16'($urandom);
		ext_lo = 16'($urandom);
		send_cmd(1'b1, FOP_FILE_INFO);
		send_word(ext_hi);
		send_word(ext_lo);
		end_frame();
		check_word("file extension high", ext_hi, ioctl_file_ext[31:16]);
		check_word("file extension low", ext_lo, ioctl_file_ext[15:0]);

		start_lo = 16'($urandom);
		start_hi = 16'($urandom);
		start = {start_hi[10:0], start_lo};
		send_cmd(1'b1, FOP_FILE_TX);
		send_word({8'($urandom), 8'($urandom) | 8'h01});
		check_word("download after start", 16'd1, {15'd0, ioctl_download});
		send_word(start_lo);
		send_word(start_hi);
		end_frame();

		send_cmd(1'b1, FOP_FILE_TX_DAT);
		for (i = 0; i < N_BYTES; i++) begin
			b = 8'($urandom);
			exp_wr_addr.push_back(start + addr_t'(i));
			exp_wr_data.push_back(b);
			send_word({8'($urandom), b});
		end
		end_frame();
		if (wr_count != N_BYTES || exp_wr_addr.size() != 0) begin
			errors++;
			$display("download gave %0d writes where %0d were expected", wr_count, N_BYTES);
		end

		send_cmd(1'b1, FOP_FILE_TX);
		send_word({8'($urandom), 8'h00});
		check_word("download after end", '0, {15'd0, ioctl_download});
		end_frame();
		send_cmd(1'b1, FOP_FILE_TX_DAT);
		send_word(16'($urandom));
		end_frame();
		if (wr_count != N_BYTES) begin
			errors++;
			$display("a data word after the end of the download produced a write");
		end
		report_test("download", err0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(SEED));
		arst_n     = 1'b0;
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		cfg_exp    = '0;
		joy0_exp   = '0;
		joy1_exp   = '0;
		status_exp = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);

		test_config();
		test_joysticks();
		test_status_write();
		test_status_request();
		test_download();

		repeat (4) @(posedge clk_sys);
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("the run timed out after %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
